// File: logic/RvCore_defs.svh
// Core sizing macros for the RV32IM execute pipeline
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// data path width in bits
`define RV_XLEN 32

// architectural integer registers
`define RV_NREGS 32

// bytes per instruction word
`define RV_INSN_SIZE 4

`endif

// File: logic/RvTypes.sv
// RISC-V instruction encoding
// Machine word, register index, major opcodes and function field values
`include "RvCore_defs.svh"

package RvTypes;
    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] regAddr_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // insn[6:0], only the forms this core executes
    typedef enum logic [6:0] {
        RvOpcode_OpImm  = 7'b0010011,
        RvOpcode_Op     = 7'b0110011,
        RvOpcode_Lui    = 7'b0110111,
        RvOpcode_Auipc  = 7'b0010111,
        RvOpcode_Jal    = 7'b1101111,
        RvOpcode_Jalr   = 7'b1100111,
        RvOpcode_Branch = 7'b1100011
    } RvOpcode;

    localparam funct7_t Funct7_Base = 7'b0000000;
    localparam funct7_t Funct7_Alt = 7'b0100000;
    localparam funct7_t Funct7_MulDiv = 7'b0000001;

    // alu forms
    localparam funct3_t Funct3_AddSub = 3'd0;
    localparam funct3_t Funct3_Sll = 3'd1;
    localparam funct3_t Funct3_Slt = 3'd2;
    localparam funct3_t Funct3_Sltu = 3'd3;
    localparam funct3_t Funct3_Xor = 3'd4;
    localparam funct3_t Funct3_Sr = 3'd5;
    localparam funct3_t Funct3_Or = 3'd6;
    localparam funct3_t Funct3_Mul = 3'd0;

    // conditional branches
    localparam funct3_t Funct3_Beq = 3'd0;
    localparam funct3_t Funct3_Bne = 3'd1;
    localparam funct3_t Funct3_Blt = 3'd4;
    localparam funct3_t Funct3_Bge = 3'd5;
    localparam funct3_t Funct3_Bltu = 3'd6;
    localparam funct3_t Funct3_Bgeu = 3'd7;
endpackage

// File: logic/OpTypes.sv
// Decoded micro-op
// Commands, operand sources and the payloads carried between pipeline stages
package OpTypes;
    import RvTypes::*;

    typedef enum logic [3:0] {
        AluCommand_Add,
        AluCommand_Sub,
        AluCommand_Sll,
        AluCommand_Slt,
        AluCommand_Sltu,
        AluCommand_Xor,
        AluCommand_Srl,
        AluCommand_Sra,
        AluCommand_Or,
        AluCommand_And
    } AluCommand;

    typedef enum logic [2:0] {
        BranchType_Equal,
        BranchType_NotEqual,
        BranchType_LessThan,
        BranchType_GreaterEqual,
        BranchType_UnsignedLessThan,
        BranchType_UnsignedGreaterEqual,
        BranchType_Always,
        BranchType_Never
    } BranchType;

    typedef enum logic [1:0] {AluSrc1_Zero, AluSrc1_Pc, AluSrc1_Reg} AluSrc1;
    typedef enum logic {AluSrc2_Imm, AluSrc2_Reg} AluSrc2;
    typedef enum logic [1:0] {ResultType_Alu, ResultType_Mul, ResultType_NextPc} ResultType;

    typedef struct packed {
        word_t pc;
        regAddr_t rs1;
        regAddr_t rs2;
        regAddr_t rd;
        word_t imm;
        AluCommand aluCommand;
        BranchType branchType;
        AluSrc1 aluSrc1;
        AluSrc2 aluSrc2;
        ResultType resultType;
        logic regWrite;
        logic illegal;
        word_t insn;  // debug only
    } DecodedOp;

    typedef struct packed {
        DecodedOp op;
        word_t rs1Value;
        word_t rs2Value;
    } ReadOp;

    typedef struct packed {
        word_t pc;
        regAddr_t rd;
        word_t value;
        logic regWrite;
        logic branchTaken;
        word_t branchTarget;
        logic illegal;
    } RetireInfo;
endpackage

// File: logic/PipeReg.sv
// Pipeline stage register
// Valid bit plus a payload of any type, frozen while hold is high
module PipeReg #(
    parameter type T = logic
) (
    input logic clk,
    input logic rst,
    input logic hold,
    input logic inValid,
    input T inData,
    output logic outValid,
    output T outData
);
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (!hold) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            outData <= inData;
        end
    end
endmodule

// File: logic/DecodeStage.sv
// Instruction decoder
// Splits RV32I/M fields, builds immediates and picks command and operand sources.
// Anything outside the supported subset comes out flagged illegal.
module DecodeStage (
    input logic insnValid,
    input RvTypes::word_t insn,
    input RvTypes::word_t pc,
    output logic opValid,
    output OpTypes::DecodedOp op
);
    import RvTypes::*;
    import OpTypes::*;

    logic [6:0] opcode;
    funct3_t funct3;
    funct7_t funct7;
    word_t immI;
    word_t immU;
    word_t immB;
    word_t immJ;
    logic legal;
    logic writes;

    function automatic AluCommand aluCommandOf(funct3_t f3, logic alt);
        case (f3)
            Funct3_AddSub: return alt ? AluCommand_Sub : AluCommand_Add;
            Funct3_Sll: return AluCommand_Sll;
            Funct3_Slt: return AluCommand_Slt;
            Funct3_Sltu: return AluCommand_Sltu;
            Funct3_Xor: return AluCommand_Xor;
            Funct3_Sr: return alt ? AluCommand_Sra : AluCommand_Srl;
            Funct3_Or: return AluCommand_Or;
            default: return AluCommand_And;
        endcase
    endfunction

    assign opcode = insn[6:0];
    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];

    assign immI = {{20{insn[31]}}, insn[31:20]};
    assign immU = {insn[31:12], 12'b0};
    assign immB = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign immJ = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

    always_comb begin
        op = '0;
        op.pc = pc;
        op.insn = insn;
        op.rd = insn[11:7];
        op.rs1 = insn[19:15];
        op.rs2 = insn[24:20];
        op.aluCommand = AluCommand_Add;
        op.branchType = BranchType_Never;
        op.aluSrc1 = AluSrc1_Reg;
        op.aluSrc2 = AluSrc2_Reg;
        op.resultType = ResultType_Alu;
        legal = 1'b1;
        writes = 1'b1;

        case (opcode)
            RvOpcode_OpImm: begin
                op.aluSrc2 = AluSrc2_Imm;
                op.imm = immI;
                // bit 30 selects sra only for shifts, addi has no sub form
                op.aluCommand = aluCommandOf(funct3, funct7[5] && funct3 == Funct3_Sr);
                if (funct3 == Funct3_Sll) begin
                    legal = funct7 == Funct7_Base;
                end else if (funct3 == Funct3_Sr) begin
                    legal = funct7 == Funct7_Base || funct7 == Funct7_Alt;
                end
            end
            RvOpcode_Op: begin
                if (funct7 == Funct7_MulDiv) begin
                    // mul only, no mulh or div
                    legal = funct3 == Funct3_Mul;
                    op.resultType = ResultType_Mul;
                end else begin
                    op.aluCommand = aluCommandOf(funct3, funct7 == Funct7_Alt);
                    legal = funct7 == Funct7_Base || (funct7 == Funct7_Alt &&
                        (funct3 == Funct3_AddSub || funct3 == Funct3_Sr));
                end
            end
            RvOpcode_Lui: begin
                op.aluSrc1 = AluSrc1_Zero;
                op.aluSrc2 = AluSrc2_Imm;
                op.imm = immU;
            end
            RvOpcode_Auipc: begin
                op.aluSrc1 = AluSrc1_Pc;
                op.aluSrc2 = AluSrc2_Imm;
                op.imm = immU;
            end
            RvOpcode_Jal: begin
                op.aluSrc1 = AluSrc1_Pc;
                op.aluSrc2 = AluSrc2_Imm;
                op.imm = immJ;
                op.branchType = BranchType_Always;
                op.resultType = ResultType_NextPc;
            end
            RvOpcode_Jalr: begin
                op.aluSrc2 = AluSrc2_Imm;
                op.imm = immI;
                op.branchType = BranchType_Always;
                op.resultType = ResultType_NextPc;
                legal = funct3 == 3'd0;
            end
            RvOpcode_Branch: begin
                op.aluSrc1 = AluSrc1_Pc;
                op.aluSrc2 = AluSrc2_Imm;
                op.imm = immB;
                writes = 1'b0;
                case (funct3)
                    Funct3_Beq: op.branchType = BranchType_Equal;
                    Funct3_Bne: op.branchType = BranchType_NotEqual;
                    Funct3_Blt: op.branchType = BranchType_LessThan;
                    Funct3_Bge: op.branchType = BranchType_GreaterEqual;
                    Funct3_Bltu: op.branchType = BranchType_UnsignedLessThan;
                    Funct3_Bgeu: op.branchType = BranchType_UnsignedGreaterEqual;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase

        if (!legal) begin
            op.branchType = BranchType_Never;
            op.resultType = ResultType_Alu;
        end
        op.illegal = !legal;
        op.regWrite = legal && writes && op.rd != '0;
    end

    assign opValid = insnValid;
endmodule

// File: logic/RegReadStage.sv
// Register read stage
// 32-entry integer register file with x0 tied to zero. Reads see a
// write from retire in the same cycle.
`include "RvCore_defs.svh"

module RegReadStage (
    input logic clk,
    input logic rst,
    input logic opValid,
    input OpTypes::DecodedOp op,
    input logic writeEnable,
    input RvTypes::regAddr_t writeAddr,
    input RvTypes::word_t writeValue,
    output logic readValid,
    output OpTypes::ReadOp readOp
);
    import RvTypes::*;
    import OpTypes::*;

    word_t regFile [`RV_NREGS];

    function automatic word_t readReg(regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (writeEnable && writeAddr == addr) begin
            return writeValue;
        end
        return regFile[addr];
    endfunction

    // x0 is never stored
    always_ff @(posedge clk) begin
        if (writeEnable && writeAddr != '0) begin
            regFile[writeAddr] <= writeValue;
        end
    end

    always_comb begin
        readOp.op = op;
        readOp.rs1Value = readReg(op.rs1);
        readOp.rs2Value = readReg(op.rs2);
    end

    assign readValid = opValid;

    // decode already drops writes to x0
    noWriteToZero: assert property (@(posedge clk) disable iff (rst)
        writeEnable |-> writeAddr != '0);
endmodule

// File: logic/MulUnit.sv
// Iterative shift-add multiplier
// One multiplier bit per cycle, finishing as soon as no set bits remain.
// Gives the low word of the product in 1 to 32 cycles.
module MulUnit (
    input logic clk,
    input logic rst,
    input logic start,
    input RvTypes::word_t src1,
    input RvTypes::word_t src2,
    output logic done,
    output RvTypes::word_t product
);
    import RvTypes::*;

    logic busy;
    word_t acc;
    word_t multiplicand;
    word_t multiplier;
    word_t partial;

    assign partial = multiplier[0] ? multiplicand : '0;
    // finishes on the step that consumes the last set bit
    assign done = busy && (multiplier >> 1) == '0;
    assign product = acc + partial;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
            multiplicand <= src1;
            multiplier <= src2;
        end else if (busy) begin
            acc <= product;
            multiplicand <= multiplicand << 1;
            multiplier <= multiplier >> 1;
        end
    end

    noStartWhileBusy: assert property (@(posedge clk) disable iff (rst) busy |-> !start);
endmodule

// File: logic/ExecuteStage.sv
// Execute stage
// ALU, branch comparator and multiplier control with bypass from the
// retire register. Holds the pipeline while a MUL is in progress.
`include "RvCore_defs.svh"

module ExecuteStage (
    input logic clk,
    input logic rst,
    input logic readValid,
    input OpTypes::ReadOp readOp,
    output logic stall,
    output logic retireValid,
    output OpTypes::RetireInfo retire
);
    import RvTypes::*;
    import OpTypes::*;

    localparam int ShiftBits = $clog2(`RV_XLEN);

    DecodedOp op;
    word_t src1Value;
    word_t src2Value;
    word_t aluSrc1;
    word_t aluSrc2;
    word_t aluResult;
    word_t mulProduct;
    logic isMul;
    logic mulStart;
    logic mulPending;
    logic mulDone;
    RetireInfo nextRetire;

    function automatic word_t alu(AluCommand command, word_t a, word_t b);
        logic [ShiftBits-1:0] shamt;
        shamt = b[ShiftBits-1:0];
        case (command)
            AluCommand_Add: return a + b;
            AluCommand_Sub: return a - b;
            AluCommand_Sll: return a << shamt;
            AluCommand_Slt: return word_t'($signed(a) < $signed(b));
            AluCommand_Sltu: return word_t'(a < b);
            AluCommand_Xor: return a ^ b;
            AluCommand_Srl: return a >> shamt;
            AluCommand_Sra: return $signed(a) >>> shamt;
            AluCommand_Or: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic compare(BranchType branchType, word_t a, word_t b);
        case (branchType)
            BranchType_Equal: return a == b;
            BranchType_NotEqual: return a != b;
            BranchType_LessThan: return $signed(a) < $signed(b);
            BranchType_GreaterEqual: return $signed(a) >= $signed(b);
            BranchType_UnsignedLessThan: return a < b;
            BranchType_UnsignedGreaterEqual: return a >= b;
            BranchType_Always: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    assign op = readOp.op;

    // retire register holds the result one instruction older
    assign src1Value = (retireValid && retire.regWrite && retire.rd == op.rs1) ?
        retire.value : readOp.rs1Value;
    assign src2Value = (retireValid && retire.regWrite && retire.rd == op.rs2) ?
        retire.value : readOp.rs2Value;

    always_comb begin
        case (op.aluSrc1)
            AluSrc1_Pc: aluSrc1 = op.pc;
            AluSrc1_Reg: aluSrc1 = src1Value;
            default: aluSrc1 = '0;
        endcase
        aluSrc2 = (op.aluSrc2 == AluSrc2_Imm) ? op.imm : src2Value;
        aluResult = alu(op.aluCommand, aluSrc1, aluSrc2);
    end

    always_comb begin
        nextRetire.pc = op.pc;
        nextRetire.rd = op.rd;
        nextRetire.regWrite = op.regWrite;
        nextRetire.illegal = op.illegal;
        case (op.resultType)
            ResultType_Mul: nextRetire.value = mulProduct;
            ResultType_NextPc: nextRetire.value = op.pc + `RV_INSN_SIZE;
            default: nextRetire.value = aluResult;
        endcase
        nextRetire.branchTaken = compare(op.branchType, src1Value, src2Value);
        if (op.branchType == BranchType_Never) begin
            nextRetire.branchTarget = '0;
        end else if (op.aluSrc1 == AluSrc1_Reg) begin
            // jalr
            nextRetire.branchTarget = aluResult & ~word_t'(1);
        end else begin
            nextRetire.branchTarget = aluResult;
        end
    end

    assign isMul = readValid && op.resultType == ResultType_Mul;
    assign mulStart = isMul && !mulPending;
    assign stall = isMul && !mulDone;

    always_ff @(posedge clk) begin
        if (rst) begin
            mulPending <= 1'b0;
        end else if (mulStart) begin
            mulPending <= 1'b1;
        end else if (mulDone) begin
            mulPending <= 1'b0;
        end
    end

    MulUnit i_MulUnit (
        .clk(clk),
        .rst(rst),
        .start(mulStart),
        .src1(src1Value),
        .src2(src2Value),
        .done(mulDone),
        .product(mulProduct)
    );

    // bubble while the mul is still running
    PipeReg #(.T(RetireInfo)) i_RetireReg (
        .clk(clk),
        .rst(rst),
        .hold(1'b0),
        .inValid(readValid && !stall),
        .inData(nextRetire),
        .outValid(retireValid),
        .outData(retire)
    );

    stallHoldsMul: assert property (@(posedge clk) disable iff (rst)
        stall |=> (readValid && $stable(readOp.op)));
endmodule

// File: logic/ExecCore.sv
// RV32IM execute pipeline top level
// Decode, register read, execute and retire joined by stage registers
module ExecCore (
    input logic clk,
    input logic rst,
    input logic insnValid,
    input RvTypes::word_t insn,
    input RvTypes::word_t pc,
    output logic stall,
    output logic retireValid,
    output RvTypes::word_t retirePc,
    output RvTypes::regAddr_t retireRd,
    output RvTypes::word_t retireValue,
    output logic retireWrite,
    output logic branchTaken,
    output RvTypes::word_t branchTarget,
    output logic illegal
);
    import OpTypes::*;

    logic decodedValid;
    DecodedOp decoded;
    logic opValid;
    DecodedOp op;
    logic readValid;
    ReadOp readOp;
    logic execValid;
    ReadOp execOp;
    RetireInfo retire;

    DecodeStage i_DecodeStage (
        .insnValid(insnValid),
        .insn(insn),
        .pc(pc),
        .opValid(decodedValid),
        .op(decoded)
    );

    PipeReg #(.T(DecodedOp)) i_DecodeReg (
        .clk(clk),
        .rst(rst),
        .hold(stall),
        .inValid(decodedValid),
        .inData(decoded),
        .outValid(opValid),
        .outData(op)
    );

    RegReadStage i_RegReadStage (
        .clk(clk),
        .rst(rst),
        .opValid(opValid),
        .op(op),
        .writeEnable(retireValid && retire.regWrite),
        .writeAddr(retire.rd),
        .writeValue(retire.value),
        .readValid(readValid),
        .readOp(readOp)
    );

    PipeReg #(.T(ReadOp)) i_ReadReg (
        .clk(clk),
        .rst(rst),
        .hold(stall),
        .inValid(readValid),
        .inData(readOp),
        .outValid(execValid),
        .outData(execOp)
    );

    ExecuteStage i_ExecuteStage (
        .clk(clk),
        .rst(rst),
        .readValid(execValid),
        .readOp(execOp),
        .stall(stall),
        .retireValid(retireValid),
        .retire(retire)
    );

    assign retirePc = retire.pc;
    assign retireRd = retire.rd;
    assign retireValue = retire.value;
    assign retireWrite = retire.regWrite;
    assign branchTaken = retire.branchTaken;
    assign branchTarget = retire.branchTarget;
    assign illegal = retire.illegal;
endmodule

// File: dv/ExecCoreTb.sv
// Testbench for the RV32IM execute pipeline
// Streams instructions from a data file and checks every retire record in order
module ExecCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ResetCycles = 5;
    localparam int CyclesPerTest = 40;
    localparam string TestFile = "dv/execTests.txt";

    typedef struct packed {
        logic [31:0] insn;
        logic [31:0] pc;
        logic [4:0] rd;
        logic [31:0] value;
        logic write;
        logic taken;
        logic [31:0] target;
        logic illegal;
    } TestVector;

    logic clk;
    logic rst;
    logic insnValid;
    logic [31:0] insn;
    logic [31:0] pc;
    logic stall;
    logic retireValid;
    logic [31:0] retirePc;
    logic [4:0] retireRd;
    logic [31:0] retireValue;
    logic retireWrite;
    logic branchTaken;
    logic [31:0] branchTarget;
    logic illegal;

    TestVector tests[$];
    TestVector pending[$];
    int retiresSeen = 0;
    logic testsLoaded = 1'b0;

    ExecCore i_ExecCore (
        .clk(clk),
        .rst(rst),
        .insnValid(insnValid),
        .insn(insn),
        .pc(pc),
        .stall(stall),
        .retireValid(retireValid),
        .retirePc(retirePc),
        .retireRd(retireRd),
        .retireValue(retireValue),
        .retireWrite(retireWrite),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .illegal(illegal)
    );

    always #5 clk = ~clk;

    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("FAIL %s: got %08h, expected %08h", name, actual, expected));
        end
    endtask

    task automatic loadTests();
        int fd;
        int fields;
        string line;
        logic [31:0] insnW;
        logic [31:0] pcW;
        logic [31:0] rdW;
        logic [31:0] valueW;
        logic [31:0] writeW;
        logic [31:0] takenW;
        logic [31:0] targetW;
        logic [31:0] illegalW;
        TestVector t;
        fd = $fopen(TestFile, "r");
        if (fd == 0) begin
            abortRun({"cannot open the test file ", TestFile});
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            // blank lines and # comments
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h", insnW, pcW, rdW, valueW,
                writeW, takenW, targetW, illegalW);
            if (fields != 8) begin
                abortRun({"malformed line in the test file: ", line});
            end
            t.insn = insnW;
            t.pc = pcW;
            t.rd = rdW[4:0];
            t.value = valueW;
            t.write = writeW[0];
            t.taken = takenW[0];
            t.target = targetW;
            t.illegal = illegalW[0];
            tests.push_back(t);
        end
        $fclose(fd);
        if (tests.size() == 0) begin
            abortRun("the test file holds no tests");
        end
    endtask

    // offer one instruction and keep it up until an edge without stall takes it
    task automatic sendInsn(TestVector t);
        insnValid = 1'b1;
        insn = t.insn;
        pc = t.pc;
        pending.push_back(t);
        while (stall) begin
            @(negedge clk);
        end
        @(negedge clk);
        insnValid = 1'b0;
    endtask

    task automatic idleGap();
        int gap;
        gap = 0;
        if ($urandom_range(3, 0) == 0) begin
            gap = $urandom_range(3, 1);
        end
        repeat (gap) @(negedge clk);
    endtask

    always @(negedge clk) begin : retireCheck
        TestVector expected;
        if (!rst && retireValid) begin
            if (pending.size() == 0) begin
                abortRun("an instruction retired while none was outstanding");
            end else begin
                expected = pending.pop_front();
                checkValue("retirePc", retirePc, expected.pc);
                checkValue("retireWrite", 32'(retireWrite), 32'(expected.write));
                checkValue("illegal", 32'(illegal), 32'(expected.illegal));
                checkValue("branchTaken", 32'(branchTaken), 32'(expected.taken));
                if (expected.write) begin
                    checkValue("retireRd", 32'(retireRd), 32'(expected.rd));
                    checkValue("retireValue", retireValue, expected.value);
                end
                if (expected.taken) begin
                    checkValue("branchTarget", branchTarget, expected.target);
                end
                retiresSeen = retiresSeen + 1;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (testsLoaded);
        limit = ResetCycles + 3 + CyclesPerTest * tests.size();
        repeat (limit) @(posedge clk);
        abortRun($sformatf("timeout, %0d of %0d expected retires never arrived",
            tests.size() - retiresSeen, tests.size()));
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        insnValid = 1'b0;
        insn = '0;
        pc = '0;
        void'($urandom(32'h069d0d9e));
        loadTests();
        testsLoaded = 1'b1;
        repeat (ResetCycles) @(negedge clk);
        rst = 1'b0;
        // empty pipeline stays quiet
        repeat (3) begin
            @(negedge clk);
            checkValue("retireValid", 32'(retireValid), 32'h0);
            checkValue("stall", 32'(stall), 32'h0);
        end
        foreach (tests[i]) begin
            sendInsn(tests[i]);
            idleGap();
        end
        while (retiresSeen < tests.size()) begin
            @(negedge clk);
        end
        // late extra retires still reach the retire check
        repeat (5) @(negedge clk);
        $display("Simulation passed");
        $finish;
    end
endmodule

// File: dv/execTests.txt
# columns, all hex: insn pc rd value write taken target illegal
# rd and value are checked when write is 1, target when taken is 1
00500093 00000100 01 00000005 1 0 00000000 0
ffd08113 00000104 02 00000002 1 0 00000000 0
002081b3 00000108 03 00000007 1 0 00000000 0
40310233 0000010c 04 fffffffb 1 0 00000000 0
123452b7 00000110 05 12345000 1 0 00000000 0
00001317 00000114 06 00001114 1 0 00000000 0
001223b3 00000118 07 00000001 1 0 00000000 0
00123433 0000011c 08 00000000 1 0 00000000 0
0ff2c493 00000120 09 123450ff 1 0 00000000 0
40225513 00000124 0a fffffffe 1 0 00000000 0
01c25593 00000128 0b 0000000f 1 0 00000000 0
00409613 0000012c 0c 00000050 1 0 00000000 0
00b666b3 00000130 0d 0000005f 1 0 00000000 0
0336f713 00000134 0e 00000013 1 0 00000000 0
00908013 00000138 00 00000000 0 0 00000000 0
001007b3 0000013c 0f 00000005 1 0 00000000 0
00f08463 00000140 00 00000000 0 1 00000148 0
00f09463 00000144 00 00000000 0 0 00000000 0
fe1248e3 00000148 00 00000000 0 1 00000138 0
00125463 0000014c 00 00000000 0 0 00000000 0
00126463 00000150 00 00000000 0 0 00000000 0
fe1278e3 00000154 00 00000000 0 1 00000144 0
0200086f 00000158 10 0000015c 1 1 00000178 0
003808e7 0000015c 11 00000160 1 1 0000015e 0
02208933 00000160 12 0000000a 1 0 00000000 0
001909b3 00000164 13 0000000f 1 0 00000000 0
02428a33 00000168 14 a4fa7000 1 0 00000000 0
413a0ab3 0000016c 15 a4fa6ff1 1 0 00000000 0
027a8b33 00000170 16 a4fa6ff1 1 0 00000000 0
02cb0bb3 00000174 17 8e42fb50 1 0 00000000 0
016bcc33 00000178 18 2ab894a1 1 0 00000000 0
ffffffff 0000017c 00 00000000 0 0 00000000 1
022090b3 00000180 00 00000000 0 0 00000000 1
0020a463 00000184 00 00000000 0 0 00000000 1
00008d93 00000188 1b 00000005 1 0 00000000 0

// File: ExecCore.f
+incdir+logic
logic/RvTypes.sv
logic/OpTypes.sv
logic/PipeReg.sv
logic/DecodeStage.sv
logic/RegReadStage.sv
logic/MulUnit.sv
logic/ExecuteStage.sv
logic/ExecCore.sv
dv/ExecCoreTb.sv

// File: runSim.sh
#!/bin/sh
# builds the ExecCore testbench with Verilator, runs it, and judges the run by its log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module ExecCoreTb -f ExecCore.f \
    -o simExecCore > build.log 2>&1 \
    && ./obj_dir/simExecCore > sim.log 2>&1
grep -q "^Simulation passed" sim.log \
    && echo "PASS: see sim.log" \
    || { echo "FAIL: see build.log and sim.log"; exit 1; }
